/* files.f */
+incdir+logic
logic/lsu_pkg.sv
logic/sram_mem.sv
logic/sram_axi_slave.sv
logic/lsu_axi_master.sv
logic/lsu_subsys_top.sv
tb/lsu_checker.sv
tb/lsu_tb.sv

/* Bender.yml */
package:
  name: lsu_subsys

sources:
  - include_dirs:
      - logic
    files:
      - logic/lsu_pkg.sv
      - logic/sram_mem.sv
      - logic/sram_axi_slave.sv
      - logic/lsu_axi_master.sv
      - logic/lsu_subsys_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tb/lsu_checker.sv
      - tb/lsu_tb.sv

/* tb/lsu_tb.sv */
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_tb;

    localparam int WIN_BYTES    = 4 << `SRAM_AW;
    localparam int DONE_TIMEOUT = 50;

    logic                   clk;
    logic                   rst;
    logic                   req;
    lsu_pkg::mem_op_e       op;
    logic [`LSU_ADDR_W-1:0] addr;
    logic [`LSU_DATA_W-1:0] wdata;
    logic                   busy;
    logic                   done;
    logic [`LSU_DATA_W-1:0] rdata;
    logic                   err;

    logic [7:0]  model [WIN_BYTES];  // byte image of the sram window
    logic [32:0] exp_q [$];          // {err, rdata}
    string       cur_test;
    int          errors;
    int          checks;
    int          tests;
    int          test_ops;
    int          test_err_base;
    bit          aborted;
    integer      seed;

    lsu_subsys_top u_dut (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .op    (op),
        .addr  (addr),
        .wdata (wdata),
        .busy  (busy),
        .done  (done),
        .rdata (rdata),
        .err   (err)
    );

    always #2 clk = ~clk;

    // expected load result and error, stores update the model
    function automatic void lsu_expect(input lsu_pkg::mem_op_e o, input logic [31:0] a,
                                       input logic [31:0] d, output logic [31:0] exp_data,
                                       output logic exp_err);
        logic [31:0] off;
        logic [7:0]  b;
        logic [15:0] h;
        logic        bad_align;
        off = a - `SRAM_BASE;
        case (o)
            lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::SH: bad_align = a[0];
            lsu_pkg::LW, lsu_pkg::SW:               bad_align = (a[1:0] != 2'b00);
            default:                                bad_align = 1'b0;
        endcase
        exp_data = '0;
        exp_err  = bad_align || (a < `SRAM_BASE) || (off >= WIN_BYTES);
        if (!exp_err) begin
            b = model[off];
            h = {model[off | 1], model[off]};
            case (o)
                lsu_pkg::LB:  exp_data = {{24{b[7]}}, b};
                lsu_pkg::LBU: exp_data = {24'h0, b};
                lsu_pkg::LH:  exp_data = {{16{h[15]}}, h};
                lsu_pkg::LHU: exp_data = {16'h0, h};
                lsu_pkg::LW:  exp_data = {model[off + 3], model[off + 2], h};
                lsu_pkg::SB:  model[off] = d[7:0];
                lsu_pkg::SH: begin
                    model[off]     = d[7:0];
                    model[off + 1] = d[15:8];
                end
                default: begin
                    for (int i = 0; i < 4; i++) begin
                        model[off + i] = d[i*8 +: 8];
                    end
                end
            endcase
        end
    endfunction

    task automatic issue_op(input lsu_pkg::mem_op_e o, input logic [31:0] a,
                            input logic [31:0] d);
        logic [31:0] exp_data;
        logic        exp_err;
        int          waited;
        waited = 0;
        while (!aborted && (busy || exp_q.size() != 0)) begin
            if (waited == 2 * DONE_TIMEOUT) begin
                $display("timeout in %s: LSU never became free for the next request", cur_test);
                errors++;
                aborted = 1'b1;
            end else begin
                @(posedge clk);
                #1;
                waited++;
            end
        end
        if (!aborted) begin
            lsu_expect(o, a, d, exp_data, exp_err);
            exp_q.push_back({exp_err, exp_data});
            req   = 1'b1;
            op    = o;
            addr  = a;
            wdata = d;
            @(posedge clk);
            #1;
            req = 1'b0;
            test_ops++;
            if (busy !== 1'b1) begin
                $display("Mismatch %s: busy after request expected 1 actual %b", cur_test, busy);
                errors++;
            end
        end
    endtask

    // pulse req while the LSU is busy, it must be ignored
    task automatic stray_req(input logic [31:0] a, input logic [31:0] d);
        if (busy) begin
            req   = 1'b1;
            op    = lsu_pkg::SW;
            addr  = a;
            wdata = d;
            @(posedge clk);
            #1;
            req = 1'b0;
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic start_test(input string name);
        cur_test      = name;
        test_ops      = 0;
        test_err_base = errors;
    endtask

    task automatic end_test();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < 2 * DONE_TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout in %s: results still outstanding at end of test", cur_test);
            errors++;
        end
        tests++;
        $display("test %s: %0d ops, %0d errors", cur_test, test_ops, errors - test_err_base);
    endtask

    // compare process, samples mid cycle
    initial begin : compare_proc
        logic [32:0] exp;
        int          wait_cycles;
        bit          after_done;
        wait_cycles = 0;
        after_done  = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            if (after_done && busy !== 1'b0) begin
                $display("Mismatch %s: busy after done expected 0 actual %b", cur_test, busy);
                errors++;
            end
            after_done = 1'b0;
            if (exp_q.size() == 0) begin
                if (!rst && done) begin
                    $display("done pulse in %s with no request outstanding", cur_test);
                    errors++;
                end
            end else if (done) begin
                exp = exp_q.pop_front();
                checks++;
                wait_cycles = 0;
                after_done  = 1'b1;
                if (busy !== 1'b1) begin
                    $display("Mismatch %s: busy at done expected 1 actual %b", cur_test, busy);
                    errors++;
                end
                if (rdata !== exp[31:0]) begin
                    $display("Mismatch %s: rdata expected %08h actual %08h",
                             cur_test, exp[31:0], rdata);
                    errors++;
                end
                if (err !== exp[32]) begin
                    $display("Mismatch %s: err expected %0b actual %0b", cur_test, exp[32], err);
                    errors++;
                end
            end else begin
                wait_cycles++;
                if (wait_cycles >= DONE_TIMEOUT) begin
                    $display("timeout in %s: no done within %0d cycles", cur_test, DONE_TIMEOUT);
                    errors++;
                    exp = exp_q.pop_front();
                    wait_cycles = 0;
                end
            end
        end
    end

    initial begin : main_proc
        logic [31:0]      r;
        logic [31:0]      off;
        logic [1:0]       lane;
        lsu_pkg::mem_op_e ro;
        clk     = 1'b0;
        rst     = 1'b1;
        req     = 1'b0;
        op      = lsu_pkg::LW;
        addr    = '0;
        wdata   = '0;
        errors  = 0;
        checks  = 0;
        tests   = 0;
        aborted = 1'b0;
        seed    = 11303;
        for (int i = 0; i < WIN_BYTES; i++) begin
            model[i] = 8'h00;
        end
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        // array powers up unknown, zero it through the bus
        start_test("clear");
        for (int i = 0; i < WIN_BYTES / 4; i++) begin
            issue_op(lsu_pkg::SW, `SRAM_BASE + 4 * i, 32'h0);
        end
        end_test();

        start_test("word_round_trip");
        for (int i = 0; i < 6; i++) begin
            off = (i == 5) ? 32'hffc : i * 32'h334;
            issue_op(lsu_pkg::SW, `SRAM_BASE + off, $random(seed));
        end
        for (int i = 0; i < 6; i++) begin
            off = (i == 5) ? 32'hffc : i * 32'h334;
            issue_op(lsu_pkg::LW, `SRAM_BASE + off, 32'h0);
        end
        end_test();

        start_test("byte_lanes");
        for (int i = 0; i < 4; i++) begin
            issue_op(lsu_pkg::SB, `SRAM_BASE + 32'h40 + i, 32'h1234_5600 | (8'h3c ^ (i * 8'h5f)));
        end
        issue_op(lsu_pkg::LW, `SRAM_BASE + 32'h40, 32'h0);
        issue_op(lsu_pkg::SH, `SRAM_BASE + 32'h44, 32'hdead_8001);
        issue_op(lsu_pkg::SH, `SRAM_BASE + 32'h46, 32'hbeef_7ffe);
        issue_op(lsu_pkg::LW, `SRAM_BASE + 32'h44, 32'h0);
        for (int i = 0; i < 8; i++) begin
            issue_op(lsu_pkg::LB, `SRAM_BASE + 32'h40 + i, 32'h0);
            issue_op(lsu_pkg::LBU, `SRAM_BASE + 32'h40 + i, 32'h0);
        end
        for (int i = 0; i < 8; i += 2) begin
            issue_op(lsu_pkg::LH, `SRAM_BASE + 32'h40 + i, 32'h0);
            issue_op(lsu_pkg::LHU, `SRAM_BASE + 32'h40 + i, 32'h0);
        end
        end_test();

        start_test("misalign");
        issue_op(lsu_pkg::SW, `SRAM_BASE + 32'h80, 32'h1122_3344);
        issue_op(lsu_pkg::LH, `SRAM_BASE + 32'h81, 32'h0);
        issue_op(lsu_pkg::LHU, `SRAM_BASE + 32'h83, 32'h0);
        issue_op(lsu_pkg::SH, `SRAM_BASE + 32'h81, 32'hffff_ffff);
        issue_op(lsu_pkg::LW, `SRAM_BASE + 32'h82, 32'h0);
        issue_op(lsu_pkg::SW, `SRAM_BASE + 32'h81, 32'haaaa_5555);
        issue_op(lsu_pkg::SW, `SRAM_BASE + 32'h83, 32'h5555_aaaa);
        issue_op(lsu_pkg::LW, `SRAM_BASE + 32'h80, 32'h0);
        end_test();

        start_test("out_of_range");
        issue_op(lsu_pkg::SW, `SRAM_BASE - 4, 32'hcafe_f00d);
        issue_op(lsu_pkg::LW, `SRAM_BASE - 4, 32'h0);
        issue_op(lsu_pkg::SW, `SRAM_BASE + WIN_BYTES, 32'h0bad_0bad);
        issue_op(lsu_pkg::LW, `SRAM_BASE + WIN_BYTES, 32'h0);
        issue_op(lsu_pkg::SB, 32'hffff_fff0, 32'h0000_00ee);
        issue_op(lsu_pkg::LB, 32'h0000_0010, 32'h0);
        issue_op(lsu_pkg::LW, `SRAM_BASE, 32'h0);
        issue_op(lsu_pkg::LW, `SRAM_BASE + WIN_BYTES - 4, 32'h0);
        end_test();

        start_test("random_mix");
        for (int i = 0; i < 300; i++) begin
            r  = $random(seed);
            ro = lsu_pkg::mem_op_e'(r[2:0]);
            case (ro)
                lsu_pkg::LB, lsu_pkg::LBU, lsu_pkg::SB: lane = r[4:3];
                lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::SH: lane = {r[4], 1'b0};
                default:                                lane = 2'b00;
            endcase
            issue_op(ro, `SRAM_BASE + {r[14:5], lane}, $random(seed));
            if (r[17]) begin
                stray_req(`SRAM_BASE + {r[27:18], 2'b00}, ~r);
            end
            idle_cycles(r[16:15]);
        end
        end_test();

        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* tb/lsu_checker.sv */
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_checker (
    input logic                     clk,
    input logic                     rst,
    input logic                     busy,
    input logic                     done,
    input logic [`LSU_ADDR_W-1:0]   axi_araddr,
    input logic                     axi_arvalid,
    input logic                     axi_arready,
    input logic [`LSU_DATA_W-1:0]   axi_rdata,
    input lsu_pkg::bus_resp_e       axi_rresp,
    input logic                     axi_rvalid,
    input logic                     axi_rready,
    input logic [`LSU_ADDR_W-1:0]   axi_awaddr,
    input logic                     axi_awvalid,
    input logic                     axi_awready,
    input logic [`LSU_DATA_W-1:0]   axi_wdata,
    input logic [`LSU_STRB_W-1:0]   axi_wstrb,
    input logic                     axi_wvalid,
    input logic                     axi_wready,
    input lsu_pkg::bus_resp_e       axi_bresp,
    input logic                     axi_bvalid,
    input logic                     axi_bready,
    input logic [`LSU_STRB_W-1:0]   mem_we
);

    // valid and payload hold until the handshake
    ar_hold: assert property (@(posedge clk) disable iff (rst)
        axi_arvalid && !axi_arready |=> axi_arvalid && $stable(axi_araddr))
        else $error("arvalid or araddr changed before AR handshake");
    aw_hold: assert property (@(posedge clk) disable iff (rst)
        axi_awvalid && !axi_awready |=> axi_awvalid && $stable(axi_awaddr))
        else $error("awvalid or awaddr changed before AW handshake");
    w_hold: assert property (@(posedge clk) disable iff (rst)
        axi_wvalid && !axi_wready |=> axi_wvalid && $stable(axi_wdata) && $stable(axi_wstrb))
        else $error("wvalid or W payload changed before W handshake");
    r_hold: assert property (@(posedge clk) disable iff (rst)
        axi_rvalid && !axi_rready |=> axi_rvalid && $stable(axi_rdata) && $stable(axi_rresp))
        else $error("rvalid or R payload changed before R handshake");
    b_hold: assert property (@(posedge clk) disable iff (rst)
        axi_bvalid && !axi_bready |=> axi_bvalid && $stable(axi_bresp))
        else $error("bvalid or bresp changed before B handshake");

    done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("done held for more than one cycle");

    // a request seen while busy starts nothing
    bus_start: assert property (@(posedge clk) disable iff (rst)
        $rose(axi_arvalid) || $rose(axi_awvalid) |-> $past(!busy))
        else $error("bus transaction started while LSU busy");

    no_err_write: assert property (@(posedge clk) disable iff (rst)
        (mem_we != '0) |=> axi_bresp == lsu_pkg::OKAY)
        else $error("memory written for a write answered with SLVERR");

endmodule

bind lsu_subsys_top lsu_checker u_checker (.*);

/* logic/lsu_subsys_top.sv */
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_subsys_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req,
    input  lsu_pkg::mem_op_e         op,
    input  logic [`LSU_ADDR_W-1:0]   addr,
    input  logic [`LSU_DATA_W-1:0]   wdata,
    output logic                     busy,
    output logic                     done,
    output logic [`LSU_DATA_W-1:0]   rdata,
    output logic                     err
);

    // lsu to slave
    logic [`LSU_ADDR_W-1:0] axi_araddr;
    logic                   axi_arvalid;
    logic                   axi_arready;
    logic [`LSU_DATA_W-1:0] axi_rdata;
    lsu_pkg::bus_resp_e     axi_rresp;
    logic                   axi_rvalid;
    logic                   axi_rready;
    logic [`LSU_ADDR_W-1:0] axi_awaddr;
    logic                   axi_awvalid;
    logic                   axi_awready;
    logic [`LSU_DATA_W-1:0] axi_wdata;
    logic [`LSU_STRB_W-1:0] axi_wstrb;
    logic                   axi_wvalid;
    logic                   axi_wready;
    lsu_pkg::bus_resp_e     axi_bresp;
    logic                   axi_bvalid;
    logic                   axi_bready;

    // slave to array
    logic                   mem_re;
    logic [`LSU_STRB_W-1:0] mem_we;
    logic [`SRAM_AW-1:0]    mem_addr;
    logic [`LSU_DATA_W-1:0] mem_wdata;
    logic [`LSU_DATA_W-1:0] mem_rdata;

    lsu_axi_master u_lsu (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .op          (op),
        .addr        (addr),
        .wdata       (wdata),
        .busy        (busy),
        .done        (done),
        .err         (err),
        .rdata       (rdata),
        .axi_araddr  (axi_araddr),
        .axi_arvalid (axi_arvalid),
        .axi_arready (axi_arready),
        .axi_rdata   (axi_rdata),
        .axi_rresp   (axi_rresp),
        .axi_rvalid  (axi_rvalid),
        .axi_rready  (axi_rready),
        .axi_awaddr  (axi_awaddr),
        .axi_awvalid (axi_awvalid),
        .axi_awready (axi_awready),
        .axi_wdata   (axi_wdata),
        .axi_wstrb   (axi_wstrb),
        .axi_wvalid  (axi_wvalid),
        .axi_wready  (axi_wready),
        .axi_bresp   (axi_bresp),
        .axi_bvalid  (axi_bvalid),
        .axi_bready  (axi_bready)
    );

    sram_axi_slave u_slave (
        .clk       (clk),
        .rst       (rst),
        .araddr    (axi_araddr),
        .arvalid   (axi_arvalid),
        .arready   (axi_arready),
        .rdata     (axi_rdata),
        .rresp     (axi_rresp),
        .rvalid    (axi_rvalid),
        .rready    (axi_rready),
        .awaddr    (axi_awaddr),
        .awvalid   (axi_awvalid),
        .awready   (axi_awready),
        .wdata     (axi_wdata),
        .wstrb     (axi_wstrb),
        .wvalid    (axi_wvalid),
        .wready    (axi_wready),
        .bresp     (axi_bresp),
        .bvalid    (axi_bvalid),
        .bready    (axi_bready),
        .mem_re    (mem_re),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    sram_mem u_mem (
        .clk   (clk),
        .rst   (rst),
        .re    (mem_re),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

endmodule

/* logic/lsu_axi_master.sv */
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_axi_master (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     req,
    input  lsu_pkg::mem_op_e         op,
    input  logic [`LSU_ADDR_W-1:0]   addr,
    input  logic [`LSU_DATA_W-1:0]   wdata,
    output logic                     busy,
    output logic                     done,
    output logic                     err,
    output logic [`LSU_DATA_W-1:0]   rdata,

    output logic [`LSU_ADDR_W-1:0]   axi_araddr,
    output logic                     axi_arvalid,
    input  logic                     axi_arready,
    input  logic [`LSU_DATA_W-1:0]   axi_rdata,
    input  lsu_pkg::bus_resp_e       axi_rresp,
    input  logic                     axi_rvalid,
    output logic                     axi_rready,
    output logic [`LSU_ADDR_W-1:0]   axi_awaddr,
    output logic                     axi_awvalid,
    input  logic                     axi_awready,
    output logic [`LSU_DATA_W-1:0]   axi_wdata,
    output logic [`LSU_STRB_W-1:0]   axi_wstrb,
    output logic                     axi_wvalid,
    input  logic                     axi_wready,
    input  lsu_pkg::bus_resp_e       axi_bresp,
    input  logic                     axi_bvalid,
    output logic                     axi_bready
);

    lsu_pkg::lsu_state_e    state;
    lsu_pkg::mem_op_e       op_q;
    logic [1:0]             lane_q;     // byte offset of the access
    logic [`LSU_DATA_W-1:0] rdata_q;
    logic                   err_q;
    logic                   is_load;
    logic                   misalign;
    logic [`LSU_STRB_W-1:0] st_strb;
    logic [`LSU_DATA_W-1:0] st_data;
    logic [`LSU_DATA_W-1:0] rd_shift;
    logic [`LSU_DATA_W-1:0] ld_data;
    logic                   aw_fin;
    logic                   w_fin;

    assign is_load = (op == lsu_pkg::LB) || (op == lsu_pkg::LH) || (op == lsu_pkg::LW) ||
                     (op == lsu_pkg::LBU) || (op == lsu_pkg::LHU);

    always_comb begin
        misalign = 1'b0;
        st_strb  = '1;
        case (op)
            lsu_pkg::LH, lsu_pkg::LHU: misalign = addr[0];
            lsu_pkg::LW, lsu_pkg::SW:  misalign = (addr[1:0] != 2'b00);
            lsu_pkg::SH: begin
                misalign = addr[0];
                st_strb  = `LSU_STRB_W'(3) << addr[1:0];
            end
            lsu_pkg::SB: st_strb = `LSU_STRB_W'(1) << addr[1:0];
            default: ;
        endcase
    end

    assign st_data = wdata << {addr[1:0], 3'b000};  // move into lanes

    // load extraction and extension
    assign rd_shift = axi_rdata >> {lane_q, 3'b000};

    always_comb begin
        case (op_q)
            lsu_pkg::LB:  ld_data = {{(`LSU_DATA_W-8){rd_shift[7]}}, rd_shift[7:0]};
            lsu_pkg::LH:  ld_data = {{(`LSU_DATA_W-16){rd_shift[15]}}, rd_shift[15:0]};
            lsu_pkg::LBU: ld_data = {{(`LSU_DATA_W-8){1'b0}}, rd_shift[7:0]};
            lsu_pkg::LHU: ld_data = {{(`LSU_DATA_W-16){1'b0}}, rd_shift[15:0]};
            lsu_pkg::LW:  ld_data = axi_rdata;
            default:      ld_data = '0;
        endcase
    end

    // channel finished this cycle or earlier
    assign aw_fin = !axi_awvalid || axi_awready;
    assign w_fin  = !axi_wvalid || axi_wready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= lsu_pkg::IDLE;
            axi_arvalid <= 1'b0;
            axi_awvalid <= 1'b0;
            axi_wvalid  <= 1'b0;
        end else begin
            case (state)
                lsu_pkg::IDLE: begin
                    if (req) begin
                        op_q    <= op;
                        lane_q  <= addr[1:0];
                        rdata_q <= '0;
                        err_q   <= misalign;
                        if (misalign) begin
                            state <= lsu_pkg::DONE;     // no bus traffic
                        end else if (is_load) begin
                            axi_araddr  <= {addr[`LSU_ADDR_W-1:2], 2'b00};
                            axi_arvalid <= 1'b1;
                            state       <= lsu_pkg::RD_ADDR;
                        end else begin
                            axi_awaddr  <= {addr[`LSU_ADDR_W-1:2], 2'b00};
                            axi_wdata   <= st_data;
                            axi_wstrb   <= st_strb;
                            axi_awvalid <= 1'b1;
                            axi_wvalid  <= 1'b1;
                            state       <= lsu_pkg::WR_REQ;
                        end
                    end
                end
                lsu_pkg::RD_ADDR: begin
                    if (axi_arready) begin
                        axi_arvalid <= 1'b0;
                        state       <= lsu_pkg::RD_DATA;
                    end
                end
                lsu_pkg::RD_DATA: begin
                    if (axi_rvalid) begin
                        rdata_q <= ld_data;
                        err_q   <= (axi_rresp == lsu_pkg::SLVERR);
                        state   <= lsu_pkg::DONE;
                    end
                end
                lsu_pkg::WR_REQ: begin
                    if (axi_awready) axi_awvalid <= 1'b0;
                    if (axi_wready) axi_wvalid <= 1'b0;
                    if (aw_fin && w_fin) state <= lsu_pkg::WR_RESP;
                end
                lsu_pkg::WR_RESP: begin
                    if (axi_bvalid) begin
                        err_q <= (axi_bresp == lsu_pkg::SLVERR);
                        state <= lsu_pkg::DONE;
                    end
                end
                default: state <= lsu_pkg::IDLE;  // DONE
            endcase
        end
    end

    assign axi_rready = (state == lsu_pkg::RD_DATA);
    assign axi_bready = (state == lsu_pkg::WR_RESP);

    assign busy  = (state != lsu_pkg::IDLE);
    assign done  = (state == lsu_pkg::DONE);
    assign err   = err_q;
    assign rdata = rdata_q;

endmodule

/* logic/sram_axi_slave.sv */
`timescale 1ns/1ps
`include "lsu_defs.svh"

module sram_axi_slave (
    input  logic                     clk,
    input  logic                     rst,

    input  logic [`LSU_ADDR_W-1:0]   araddr,
    input  logic                     arvalid,
    output logic                     arready,

    output logic [`LSU_DATA_W-1:0]   rdata,
    output lsu_pkg::bus_resp_e       rresp,
    output logic                     rvalid,
    input  logic                     rready,

    input  logic [`LSU_ADDR_W-1:0]   awaddr,
    input  logic                     awvalid,
    output logic                     awready,

    input  logic [`LSU_DATA_W-1:0]   wdata,
    input  logic [`LSU_STRB_W-1:0]   wstrb,
    input  logic                     wvalid,
    output logic                     wready,

    output lsu_pkg::bus_resp_e       bresp,
    output logic                     bvalid,
    input  logic                     bready,

    output logic                     mem_re,
    output logic [`LSU_STRB_W-1:0]   mem_we,
    output logic [`SRAM_AW-1:0]      mem_addr,
    output logic [`LSU_DATA_W-1:0]   mem_wdata,
    input  logic [`LSU_DATA_W-1:0]   mem_rdata
);

    logic [`LSU_ADDR_W-1:0] rd_addr_q;
    logic [`LSU_ADDR_W-1:0] wr_addr_q;
    logic [`LSU_DATA_W-1:0] wr_data_q;
    logic [`LSU_STRB_W-1:0] wr_strb_q;
    logic [`LSU_ADDR_W-1:0] rd_off;
    logic [`LSU_ADDR_W-1:0] wr_off;
    logic                   rd_ok;
    logic                   wr_ok;
    logic                   rd_issue;   // memory read cycle
    logic                   rd_fetch;   // memory data ready
    logic                   aw_done;
    logic                   w_done;
    logic                   commit;

    // window decode, addresses below base wrap high
    assign rd_off = rd_addr_q - `SRAM_BASE;
    assign wr_off = wr_addr_q - `SRAM_BASE;
    assign rd_ok  = (rd_off[`LSU_ADDR_W-1:`SRAM_AW+2] == '0);
    assign wr_ok  = (wr_off[`LSU_ADDR_W-1:`SRAM_AW+2] == '0);

    assign commit = aw_done && w_done;

    assign mem_re    = rd_issue && rd_ok;
    assign mem_we    = (commit && wr_ok) ? wr_strb_q : '0;  // dropped outside window
    assign mem_addr  = rd_issue ? rd_off[`SRAM_AW+1:2] : wr_off[`SRAM_AW+1:2];
    assign mem_wdata = wr_data_q;

    // read side
    always_ff @(posedge clk) begin
        if (rst) begin
            arready  <= 1'b1;
            rd_issue <= 1'b0;
            rd_fetch <= 1'b0;
            rvalid   <= 1'b0;
        end else begin
            rd_issue <= arvalid && arready;
            rd_fetch <= rd_issue;
            if (arvalid && arready) begin
                arready   <= 1'b0;
                rd_addr_q <= araddr;
            end
            if (rd_fetch) begin
                rvalid <= 1'b1;
                rdata  <= rd_ok ? mem_rdata : '0;
                rresp  <= rd_ok ? lsu_pkg::OKAY : lsu_pkg::SLVERR;
            end else if (rvalid && rready) begin
                rvalid  <= 1'b0;
                arready <= 1'b1;    // next read only after R
            end
        end
    end

    // write side, aw and w may land in either order
    always_ff @(posedge clk) begin
        if (rst) begin
            awready <= 1'b1;
            wready  <= 1'b1;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            if (awvalid && awready) begin
                awready   <= 1'b0;
                aw_done   <= 1'b1;
                wr_addr_q <= awaddr;
            end
            if (wvalid && wready) begin
                wready    <= 1'b0;
                w_done    <= 1'b1;
                wr_data_q <= wdata;
                wr_strb_q <= wstrb;
            end
            if (commit) begin
                aw_done <= 1'b0;
                w_done  <= 1'b0;
                bvalid  <= 1'b1;
                bresp   <= wr_ok ? lsu_pkg::OKAY : lsu_pkg::SLVERR;
            end else if (bvalid && bready) begin
                bvalid  <= 1'b0;
                awready <= 1'b1;
                wready  <= 1'b1;
            end
        end
    end

endmodule

/* logic/sram_mem.sv */
`timescale 1ns/1ps
`include "lsu_defs.svh"

module sram_mem (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     re,
    input  logic [`LSU_STRB_W-1:0]   we,
    input  logic [`SRAM_AW-1:0]      addr,
    input  logic [`LSU_DATA_W-1:0]   wdata,
    output logic [`LSU_DATA_W-1:0]   rdata
);

    localparam int DEPTH = 1 << `SRAM_AW;

    logic [`LSU_DATA_W-1:0] mem [DEPTH];

    // per lane write
    always_ff @(posedge clk) begin
        for (int i = 0; i < `LSU_STRB_W; i++) begin
            if (we[i]) begin
                mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
            end
        end
    end

    // registered read port, holds between reads
    always_ff @(posedge clk) begin
        if (rst) begin
            rdata <= '0;
        end else if (re) begin
            rdata <= mem[addr];
        end
    end

endmodule

/* logic/lsu_pkg.sv */
package lsu_pkg;

    // core memory operations
    typedef enum logic [2:0] {
        LB  = 3'd0,
        LH  = 3'd1,
        LW  = 3'd2,
        LBU = 3'd3,
        LHU = 3'd4,
        SB  = 3'd5,
        SH  = 3'd6,
        SW  = 3'd7
    } mem_op_e;

    typedef enum logic [2:0] {
        IDLE,
        RD_ADDR,
        RD_DATA,
        WR_REQ,
        WR_RESP,
        DONE
    } lsu_state_e;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } bus_resp_e;

endpackage

/* logic/lsu_defs.svh */
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// core and bus widths
`define LSU_ADDR_W 32
`define LSU_DATA_W 32

// byte lanes per data word
`define LSU_STRB_W 4

// sram geometry, 1024 words
`define SRAM_AW 10

// first byte of the sram window, same as the core reset vector
`define SRAM_BASE 32'h8000_0000

`endif
